// ==== hdl/ccu_pkg.sv ====
package ccu_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  id_t;

    // Read snoop opcodes, ACE encoding
    typedef enum logic [3:0] {
        READ_SHARED = 4'b0001,
        READ_CLEAN  = 4'b0010,
        READ_UNIQUE = 4'b0111
    } snoop_op_e;

    // Snoop response on CR
    typedef struct packed {
        logic data_transfer;
        logic error;
        logic pass_dirty;
        logic is_shared;
        logic was_unique;
    } cr_resp_t;

    // R response, bits 1:0 hold the error code (2 is slave error)
    typedef logic [3:0] rresp_t;

    localparam int unsigned RESP_SHARED     = 3;
    localparam int unsigned RESP_PASS_DIRTY = 2;

    typedef struct packed {
        addr_t     addr;
        id_t       id;
        snoop_op_e snoop_op;
        logic      accepts_dirty;
    } ar_req_t;

    typedef struct packed {
        data_t  data;
        id_t    id;
        rresp_t resp;
        logic   last;
    } r_beat_t;

    typedef struct packed {
        addr_t     addr;
        snoop_op_e snoop_op;
    } ac_req_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } cd_beat_t;

    // One whole line to or from memory
    typedef struct packed {
        addr_t addr;
        logic  write;
    } mem_cmd_t;

    // Wishbone classic, master side
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        addr_t      adr;
        data_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        data_t dat;
        logic  ack;
    } wb_rsp_t;

endpackage

// ==== hdl/stream_fork.sv ====
`timescale 1ns/1ps

module stream_fork #(
    parameter int unsigned N_OUP = 2
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             valid_i,
    output logic             ready_o,
    input  logic [N_OUP-1:0] sel_i,
    output logic [N_OUP-1:0] valid_o,
    input  logic [N_OUP-1:0] ready_i
);

    // Outputs that have already taken the current beat
    logic [N_OUP-1:0] done_q;
    logic [N_OUP-1:0] taken;

    // Offer the beat only where it is selected and not yet taken
    assign valid_o = {N_OUP{valid_i}} & sel_i & ~done_q;

    assign taken = done_q | (valid_o & ready_i);

    // Consume the input once every selected output is served
    // An empty select consumes it right away
    assign ready_o = &(~sel_i | taken);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_q <= '0;
        end else if (valid_i) begin
            if (ready_o) begin
                done_q <= '0;
            end else begin
                done_q <= taken;
            end
        end
    end

endmodule

// ==== hdl/wb_line_master.sv ====
`timescale 1ns/1ps

module wb_line_master import ccu_pkg::*; #(
    parameter int unsigned LINE_BEATS = 4
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     cmd_valid_i,
    output logic     cmd_ready_o,
    input  mem_cmd_t cmd_i,
    input  logic     wdata_valid_i,
    output logic     wdata_ready_o,
    input  data_t    wdata_i,
    output logic     rdata_valid_o,
    input  logic     rdata_ready_i,
    output data_t    rdata_o,
    output wb_req_t  wb_o,
    input  wb_rsp_t  wb_i
);

    localparam int unsigned CNT_W = $clog2(LINE_BEATS);

    typedef enum logic [1:0] {IDLE, WRITE, READ} state_e;

    state_e           state_q;
    logic [CNT_W-1:0] beat_q;
    addr_t            adr_q;
    logic             rvalid_q;
    data_t            rdata_q;
    logic             beat_done;
    logic             last_beat;

    assign last_beat = (beat_q == CNT_W'(LINE_BEATS - 1));
    assign beat_done = wb_o.stb && wb_i.ack;

    assign cmd_ready_o   = (state_q == IDLE);
    assign wdata_ready_o = (state_q == WRITE) && wb_i.ack;
    assign rdata_valid_o = rvalid_q;
    assign rdata_o       = rdata_q;

    always_comb begin
        wb_o.cyc = (state_q != IDLE);
        wb_o.we  = (state_q == WRITE);
        wb_o.adr = adr_q;
        wb_o.sel = '1;
        wb_o.dat = (state_q == WRITE) ? wdata_i : '0;
        unique case (state_q)
            // One strobe per write beat, held until ack
            WRITE: wb_o.stb = wdata_valid_i;
            // Wait for room in the read buffer
            READ:    wb_o.stb = !rvalid_q || rdata_ready_i;
            default: wb_o.stb = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            beat_q   <= '0;
            rvalid_q <= 1'b0;
        end else begin
            if (rdata_valid_o && rdata_ready_i) begin
                rvalid_q <= 1'b0;
            end
            if (state_q == IDLE) begin
                if (cmd_valid_i) begin
                    state_q <= cmd_i.write ? WRITE : READ;
                    beat_q  <= '0;
                end
            end else if (beat_done) begin
                // A new read word wins over the buffer being emptied
                if (state_q == READ) begin
                    rvalid_q <= 1'b1;
                end
                beat_q <= beat_q + CNT_W'(1);
                if (last_beat) begin
                    state_q <= IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i && cmd_ready_o) begin
            adr_q <= cmd_i.addr;
        end else if (beat_done) begin
            adr_q <= adr_q + 32'd4;
        end
        if (beat_done && state_q == READ) begin
            rdata_q <= wb_i.dat;
        end
    end

endmodule

// ==== hdl/ccu_read_snoop.sv ====
`timescale 1ns/1ps

module ccu_read_snoop import ccu_pkg::*; #(
    parameter int unsigned LINE_BEATS = 4
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    // Initiator
    input  logic     ar_valid_i,
    output logic     ar_ready_o,
    input  ar_req_t  ar_i,
    output logic     r_valid_o,
    input  logic     r_ready_i,
    output r_beat_t  r_o,
    // Peer cache
    output logic     ac_valid_o,
    input  logic     ac_ready_i,
    output ac_req_t  ac_o,
    input  logic     cr_valid_i,
    output logic     cr_ready_o,
    input  cr_resp_t cr_i,
    input  logic     cd_valid_i,
    output logic     cd_ready_o,
    input  cd_beat_t cd_i,
    // Memory line master
    output logic     mem_cmd_valid_o,
    input  logic     mem_cmd_ready_i,
    output mem_cmd_t mem_cmd_o,
    output logic     mw_valid_o,
    input  logic     mw_ready_i,
    output data_t    mw_data_o,
    input  logic     mr_valid_i,
    output logic     mr_ready_o,
    input  data_t    mr_data_i
);

    localparam int unsigned CNT_W  = $clog2(LINE_BEATS);
    // Fork outputs
    localparam int unsigned R_IDX  = 0;
    localparam int unsigned MW_IDX = 1;

    typedef enum logic [2:0] {
        SNOOP_REQ,
        SNOOP_RESP,
        WRITE_CD,
        IGNORE_CD,
        READ_MEM
    } state_e;

    state_e           state_q, state_d;
    ar_req_t          ar_q;
    logic [1:0]       sel_q, sel_d;
    logic             shared_q, shared_d;
    logic             dirty_q, dirty_d;
    logic             cmd_pend_q, cmd_pend_d;
    logic             r_done_q, r_done_d;
    logic             w_done_q, w_done_d;
    logic [CNT_W-1:0] beat_q;
    logic             ac_hs, r_hs, cd_hs, mw_hs;
    logic             r_last_hs, mw_last_hs;
    logic             cd_active;
    logic             fork_ready;
    logic [1:0]       fork_valid;
    logic [1:0]       out_ready;

    assign ac_hs      = ac_valid_o && ac_ready_i;
    assign r_hs       = r_valid_o && r_ready_i;
    assign cd_hs      = cd_valid_i && cd_ready_o;
    assign mw_hs      = mw_valid_o && mw_ready_i;
    assign r_last_hs  = r_hs && r_o.last;
    // The write beat of the CD last word completes on the final ack
    assign mw_last_hs = mw_hs && cd_i.last;

    assign cd_active  = (state_q == WRITE_CD) || (state_q == IGNORE_CD);
    assign cd_ready_o = cd_active && fork_ready;
    assign out_ready  = {mw_ready_i, r_ready_i};
    assign mw_valid_o = fork_valid[MW_IDX];
    assign mw_data_o  = cd_i.data;
    assign cr_ready_o = (state_q == SNOOP_RESP);

    assign mem_cmd_valid_o = cmd_pend_q;
    assign mem_cmd_o.addr  = ar_q.addr;
    assign mem_cmd_o.write = (state_q == WRITE_CD);

    always_comb begin
        ar_ready_o    = 1'b0;
        ac_valid_o    = 1'b0;
        ac_o.addr     = ar_i.addr;
        ac_o.snoop_op = ar_i.snoop_op;
        r_valid_o     = 1'b0;
        mr_ready_o    = 1'b0;
        r_o.data      = cd_i.data;
        r_o.id        = ar_q.id;
        r_o.resp      = '0;
        r_o.last      = (beat_q == CNT_W'(LINE_BEATS - 1));
        case (state_q)
            // AR goes through only together with AC
            SNOOP_REQ: begin
                ac_valid_o = ar_valid_i;
                ar_ready_o = ac_ready_i;
            end
            WRITE_CD: begin
                r_valid_o                 = fork_valid[R_IDX];
                r_o.resp[RESP_SHARED]     = shared_q;
                r_o.resp[RESP_PASS_DIRTY] = dirty_q;
            end
            READ_MEM: begin
                r_valid_o  = mr_valid_i;
                r_o.data   = mr_data_i;
                mr_ready_o = r_ready_i;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        state_d    = state_q;
        sel_d      = sel_q;
        shared_d   = shared_q;
        dirty_d    = dirty_q;
        cmd_pend_d = cmd_pend_q && !mem_cmd_ready_i;
        r_done_d   = r_done_q || r_last_hs;
        w_done_d   = w_done_q || mw_last_hs;
        case (state_q)
            SNOOP_REQ: begin
                r_done_d = 1'b0;
                w_done_d = 1'b0;
                if (ac_hs) begin
                    state_d = SNOOP_RESP;
                end
            end
            SNOOP_RESP: begin
                if (cr_valid_i) begin
                    sel_d    = '0;
                    shared_d = cr_i.is_shared;
                    dirty_d  = 1'b0;
                    if (cr_i.data_transfer && !cr_i.error) begin
                        state_d        = WRITE_CD;
                        sel_d[R_IDX]   = 1'b1;
                        if (cr_i.pass_dirty) begin
                            if (ar_q.accepts_dirty) begin
                                dirty_d = 1'b1;
                            end else begin
                                // Initiator refuses dirty data, write it back too
                                sel_d[MW_IDX] = 1'b1;
                                cmd_pend_d    = 1'b1;
                            end
                        end
                    end else if (cr_i.data_transfer) begin
                        state_d = IGNORE_CD;
                    end else begin
                        state_d    = READ_MEM;
                        cmd_pend_d = 1'b1;
                    end
                end
            end
            // Done after R last and, with write-back, the final memory ack
            WRITE_CD: begin
                if (r_done_d && (w_done_d || !sel_q[MW_IDX])) begin
                    state_d = SNOOP_REQ;
                end
            end
            IGNORE_CD: begin
                if (cd_hs && cd_i.last) begin
                    state_d    = READ_MEM;
                    cmd_pend_d = 1'b1;
                end
            end
            READ_MEM: begin
                if (r_last_hs) begin
                    state_d = SNOOP_REQ;
                end
            end
            default: state_d = SNOOP_REQ;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= SNOOP_REQ;
            sel_q      <= '0;
            shared_q   <= 1'b0;
            dirty_q    <= 1'b0;
            cmd_pend_q <= 1'b0;
            r_done_q   <= 1'b0;
            w_done_q   <= 1'b0;
            beat_q     <= '0;
        end else begin
            state_q    <= state_d;
            sel_q      <= sel_d;
            shared_q   <= shared_d;
            dirty_q    <= dirty_d;
            cmd_pend_q <= cmd_pend_d;
            r_done_q   <= r_done_d;
            w_done_q   <= w_done_d;
            if (state_q == SNOOP_REQ) begin
                beat_q <= '0;
            end else if (r_hs) begin
                beat_q <= beat_q + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ac_hs) begin
            ar_q <= ar_i;
        end
    end

    // CD split between initiator R and memory write-back
    stream_fork #(
        .N_OUP (2)
    ) i_cd_fork (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (cd_valid_i && cd_active),
        .ready_o (fork_ready),
        .sel_i   (sel_q),
        .valid_o (fork_valid),
        .ready_i (out_ready)
    );

endmodule

// ==== hdl/ccu_top.sv ====
`timescale 1ns/1ps

module ccu_top import ccu_pkg::*; #(
    parameter int unsigned LINE_BEATS = 4
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     ar_valid_i,
    output logic     ar_ready_o,
    input  ar_req_t  ar_i,
    output logic     r_valid_o,
    input  logic     r_ready_i,
    output r_beat_t  r_o,
    output logic     ac_valid_o,
    input  logic     ac_ready_i,
    output ac_req_t  ac_o,
    input  logic     cr_valid_i,
    output logic     cr_ready_o,
    input  cr_resp_t cr_i,
    input  logic     cd_valid_i,
    output logic     cd_ready_o,
    input  cd_beat_t cd_i,
    output wb_req_t  wb_o,
    input  wb_rsp_t  wb_i
);

    // Line command and data streams to the memory master
    logic     mem_cmd_valid;
    logic     mem_cmd_ready;
    mem_cmd_t mem_cmd;
    logic     mw_valid;
    logic     mw_ready;
    data_t    mw_data;
    logic     mr_valid;
    logic     mr_ready;
    data_t    mr_data;

    ccu_read_snoop #(
        .LINE_BEATS (LINE_BEATS)
    ) i_read_snoop (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ar_valid_i      (ar_valid_i),
        .ar_ready_o      (ar_ready_o),
        .ar_i            (ar_i),
        .r_valid_o       (r_valid_o),
        .r_ready_i       (r_ready_i),
        .r_o             (r_o),
        .ac_valid_o      (ac_valid_o),
        .ac_ready_i      (ac_ready_i),
        .ac_o            (ac_o),
        .cr_valid_i      (cr_valid_i),
        .cr_ready_o      (cr_ready_o),
        .cr_i            (cr_i),
        .cd_valid_i      (cd_valid_i),
        .cd_ready_o      (cd_ready_o),
        .cd_i            (cd_i),
        .mem_cmd_valid_o (mem_cmd_valid),
        .mem_cmd_ready_i (mem_cmd_ready),
        .mem_cmd_o       (mem_cmd),
        .mw_valid_o      (mw_valid),
        .mw_ready_i      (mw_ready),
        .mw_data_o       (mw_data),
        .mr_valid_i      (mr_valid),
        .mr_ready_o      (mr_ready),
        .mr_data_i       (mr_data)
    );

    wb_line_master #(
        .LINE_BEATS (LINE_BEATS)
    ) i_wb_master (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cmd_valid_i   (mem_cmd_valid),
        .cmd_ready_o   (mem_cmd_ready),
        .cmd_i         (mem_cmd),
        .wdata_valid_i (mw_valid),
        .wdata_ready_o (mw_ready),
        .wdata_i       (mw_data),
        .rdata_valid_o (mr_valid),
        .rdata_ready_i (mr_ready),
        .rdata_o       (mr_data),
        .wb_o          (wb_o),
        .wb_i          (wb_i)
    );

endmodule

// ==== dv/ccu_asserts.sv ====
`timescale 1ns/1ps

module ccu_asserts import ccu_pkg::*; (
    input logic    clk_i,
    input logic    rst_ni,
    input logic    r_valid_o,
    input logic    r_ready_i,
    input r_beat_t r_o,
    input logic    ac_valid_o,
    input logic    ac_ready_i,
    input ac_req_t ac_o,
    input wb_req_t wb_o
);

    // R beat stays offered with the same payload until it is taken
    r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
        else $error("R valid dropped or payload changed before ready");

    // Same rule for the snoop request
    ac_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ac_valid_o && !ac_ready_i |=> ac_valid_o && $stable(ac_o))
        else $error("AC valid dropped or payload changed before ready");

    // Wishbone strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_o.stb |-> wb_o.cyc)
        else $error("Wishbone stb high while cyc is low");

endmodule

bind ccu_top ccu_asserts i_asserts (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_o        (r_o),
    .ac_valid_o (ac_valid_o),
    .ac_ready_i (ac_ready_i),
    .ac_o       (ac_o),
    .wb_o       (wb_o)
);

// ==== dv/ccu_tb.sv ====
`timescale 1ns/1ps

module ccu_tb import ccu_pkg::*; ();

    localparam int unsigned LINE_BEATS = 4;
    localparam int          N_ROWS     = 12;
    localparam int          MAX_CYCLES = N_ROWS * 200;
    localparam int          SEED       = 45791;

    typedef struct packed {
        addr_t     addr;
        snoop_op_e op;
        logic      accepts_dirty;
        cr_resp_t  cr;
        data_t     seed;
        logic      stall;
        logic      from_peer;
        rresp_t    resp;
        logic      wback;
    } row_t;

    // cr bits: data_transfer, error, pass_dirty, is_shared, was_unique
    localparam row_t ROWS [N_ROWS] = '{
        // addr, op, accepts_dirty, cr, seed, stall, from_peer, resp, wback
        '{32'h0000_1000, READ_SHARED, 1'b0, 5'b00000, 32'h0000_0000, 1'b0, 1'b0, 4'h0, 1'b0},
        '{32'h0000_2000, READ_SHARED, 1'b0, 5'b10010, 32'h1111_0000, 1'b0, 1'b1, 4'h8, 1'b0},
        '{32'h0000_2040, READ_CLEAN,  1'b0, 5'b10001, 32'h2222_0000, 1'b0, 1'b1, 4'h0, 1'b0},
        '{32'h0000_3000, READ_UNIQUE, 1'b1, 5'b10101, 32'h3333_0000, 1'b0, 1'b1, 4'h4, 1'b0},
        '{32'h0000_4000, READ_SHARED, 1'b0, 5'b10110, 32'h4444_0000, 1'b0, 1'b1, 4'h8, 1'b1},
        '{32'h0000_4000, READ_SHARED, 1'b0, 5'b00000, 32'h0000_0000, 1'b0, 1'b0, 4'h0, 1'b0},
        '{32'h0000_5000, READ_CLEAN,  1'b0, 5'b11000, 32'h5555_0000, 1'b0, 1'b0, 4'h0, 1'b0},
        '{32'h0000_6000, READ_SHARED, 1'b0, 5'b10010, 32'h6666_0000, 1'b1, 1'b1, 4'h8, 1'b0},
        '{32'h0000_6100, READ_CLEAN,  1'b0, 5'b00000, 32'h0000_0000, 1'b1, 1'b0, 4'h0, 1'b0},
        '{32'h0000_7000, READ_UNIQUE, 1'b0, 5'b10100, 32'h7777_0000, 1'b1, 1'b1, 4'h0, 1'b1},
        '{32'h0000_7000, READ_SHARED, 1'b0, 5'b00000, 32'h0000_0000, 1'b1, 1'b0, 4'h0, 1'b0},
        '{32'h0000_5040, READ_SHARED, 1'b0, 5'b11010, 32'h8888_0000, 1'b1, 1'b0, 4'h0, 1'b0}
    };

    logic     clk_i = 1'b0;
    logic     rst_ni;
    logic     ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
    logic     ac_valid_o, ac_ready_i, cr_valid_i, cr_ready_o, cd_valid_i, cd_ready_o;
    ar_req_t  ar_i;
    r_beat_t  r_o;
    ac_req_t  ac_o;
    cr_resp_t cr_i;
    cd_beat_t cd_i;
    wb_req_t  wb_o;
    wb_rsp_t  wb_i;

    int       errors;
    int       checks;
    int       cycles = 0;
    logic     peer_busy;
    data_t    mem [addr_t];
    // Logs filled by the models, checked by the row sequence
    addr_t    rd_adr_q [$];
    addr_t    wr_adr_q [$];
    data_t    wr_dat_q [$];
    ac_req_t  ac_q [$];

    always #10 clk_i = ~clk_i;

    ccu_top #(
        .LINE_BEATS (LINE_BEATS)
    ) DUT (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .ar_i       (ar_i),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .r_o        (r_o),
        .ac_valid_o (ac_valid_o),
        .ac_ready_i (ac_ready_i),
        .ac_o       (ac_o),
        .cr_valid_i (cr_valid_i),
        .cr_ready_o (cr_ready_o),
        .cr_i       (cr_i),
        .cd_valid_i (cd_valid_i),
        .cd_ready_o (cd_ready_o),
        .cd_i       (cd_i),
        .wb_o       (wb_o),
        .wb_i       (wb_i)
    );

    // Untouched memory words, every address bit takes part
    function automatic data_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic data_t mem_word(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    task automatic report_mismatch(string what, data_t got, data_t exp);
        errors++;
        $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
    endtask

    task automatic check_beat(int idx, int beat);
        row_t  row;
        data_t exp;
        row = ROWS[idx];
        exp = row.from_peer ? row.seed + data_t'(beat) : mem_word(row.addr + addr_t'(4 * beat));
        checks += 4;
        if (r_o.data !== exp) begin
            report_mismatch($sformatf("row %0d beat %0d R data", idx, beat), r_o.data, exp);
        end
        if (r_o.resp !== row.resp) begin
            report_mismatch($sformatf("row %0d beat %0d R resp", idx, beat),
                            data_t'(r_o.resp), data_t'(row.resp));
        end
        if (r_o.id !== id_t'(idx)) begin
            report_mismatch($sformatf("row %0d R id", idx), data_t'(r_o.id), data_t'(idx));
        end
        if (r_o.last !== (beat == LINE_BEATS - 1)) begin
            report_mismatch($sformatf("row %0d beat %0d R last", idx, beat),
                            data_t'(r_o.last), data_t'(beat == LINE_BEATS - 1));
        end
    endtask

    task automatic check_memory(int idx, int rd_base, int wr_base);
        row_t row;
        int   exp_rd;
        int   exp_wr;
        row    = ROWS[idx];
        exp_rd = row.from_peer ? 0 : LINE_BEATS;
        exp_wr = row.wback ? LINE_BEATS : 0;
        checks += 2;
        if (rd_adr_q.size() - rd_base != exp_rd) begin
            report_mismatch($sformatf("row %0d memory reads", idx),
                            data_t'(rd_adr_q.size() - rd_base), data_t'(exp_rd));
        end else begin
            for (int i = 0; i < exp_rd; i++) begin
                if (rd_adr_q[rd_base + i] !== row.addr + addr_t'(4 * i)) begin
                    report_mismatch($sformatf("row %0d read adr", idx),
                                    rd_adr_q[rd_base + i], row.addr + addr_t'(4 * i));
                end
            end
        end
        if (wr_adr_q.size() - wr_base != exp_wr) begin
            report_mismatch($sformatf("row %0d memory writes", idx),
                            data_t'(wr_adr_q.size() - wr_base), data_t'(exp_wr));
        end else begin
            for (int i = 0; i < exp_wr; i++) begin
                checks += 2;
                if (wr_adr_q[wr_base + i] !== row.addr + addr_t'(4 * i)) begin
                    report_mismatch($sformatf("row %0d write adr", idx),
                                    wr_adr_q[wr_base + i], row.addr + addr_t'(4 * i));
                end
                if (wr_dat_q[wr_base + i] !== row.seed + data_t'(i)) begin
                    report_mismatch($sformatf("row %0d write data", idx),
                                    wr_dat_q[wr_base + i], row.seed + data_t'(i));
                end
            end
        end
    endtask

    task automatic run_row(int idx);
        row_t row;
        int   beat;
        int   err_before;
        int   rd_base;
        int   wr_base;
        row        = ROWS[idx];
        err_before = errors;
        rd_base    = rd_adr_q.size();
        wr_base    = wr_adr_q.size();
        ar_i       = '{addr: row.addr, id: id_t'(idx), snoop_op: row.op,
                       accepts_dirty: row.accepts_dirty};
        ar_valid_i = 1'b1;
        @(posedge clk_i);
        while (!ar_ready_o) @(posedge clk_i);
        #2;
        ar_valid_i = 1'b0;
        beat = 0;
        while (beat < LINE_BEATS) begin
            @(posedge clk_i);
            if (r_valid_o && r_ready_i) begin
                check_beat(idx, beat);
                beat++;
            end
            #2;
            r_ready_i = row.stall ? ($urandom_range(0, 1) != 0) : 1'b1;
        end
        r_ready_i = 1'b1;
        // Back in idle once AR would be taken again
        @(posedge clk_i);
        while (!ar_ready_o) @(posedge clk_i);
        #2;
        checks++;
        if (ac_q.size() != idx + 1) begin
            report_mismatch("snoop count", data_t'(ac_q.size()), data_t'(idx + 1));
        end else if (ac_q[idx].addr !== row.addr || ac_q[idx].snoop_op !== row.op) begin
            report_mismatch($sformatf("row %0d AC addr", idx), ac_q[idx].addr, row.addr);
        end
        check_memory(idx, rd_base, wr_base);
        if (peer_busy) begin
            errors++;
            $display("Row %0d ended while the peer still had snoop data to deliver", idx);
        end
        $display("Row %0d addr %h: %s", idx, row.addr, (errors == err_before) ? "ok" : "mismatch");
    endtask

    // Peer cache answers each snoop from the row it belongs to
    // On stall rows it also holds off the snoop request now and then
    initial begin : peer_cache
        row_t row;
        ac_ready_i = 1'b1;
        cr_valid_i = 1'b0;
        cr_i       = '0;
        cd_valid_i = 1'b0;
        cd_i       = '0;
        peer_busy  = 1'b0;
        forever begin
            @(posedge clk_i);
            if (ac_valid_o && ac_ready_i) begin
                row = ROWS[ac_q.size()];
                ac_q.push_back(ac_o);
                peer_busy = 1'b1;
                #2;
                cr_valid_i = 1'b1;
                cr_i       = row.cr;
                @(posedge clk_i);
                while (!cr_ready_o) @(posedge clk_i);
                #2;
                cr_valid_i = 1'b0;
                if (row.cr.data_transfer) begin
                    for (int b = 0; b < LINE_BEATS; b++) begin
                        cd_valid_i = 1'b1;
                        cd_i.data  = row.seed + data_t'(b);
                        cd_i.last  = (b == LINE_BEATS - 1);
                        @(posedge clk_i);
                        while (!cd_ready_o) @(posedge clk_i);
                        #2;
                    end
                    cd_valid_i = 1'b0;
                end
                peer_busy = 1'b0;
            end else if (ac_q.size() < N_ROWS) begin
                #2;
                ac_ready_i = ROWS[ac_q.size()].stall ? ($urandom_range(0, 1) != 0) : 1'b1;
            end
        end
    end

    // Wishbone slave with registered ack after 0 to 2 wait cycles
    initial begin : wb_memory
        int    wait_cnt;
        logic  ack_next;
        data_t dat_next;
        wb_i     = '0;
        wait_cnt = 0;
        forever begin
            @(posedge clk_i);
            ack_next = 1'b0;
            dat_next = wb_i.dat;
            if (wb_o.cyc && wb_o.stb && wb_i.ack) begin
                // Every beat carries a whole word
                checks++;
                if (wb_o.sel !== 4'hF) begin
                    report_mismatch("Wishbone sel", data_t'(wb_o.sel), 32'h0000_000F);
                end
                if (wb_o.we) begin
                    mem[wb_o.adr] = wb_o.dat;
                    wr_adr_q.push_back(wb_o.adr);
                    wr_dat_q.push_back(wb_o.dat);
                end else begin
                    rd_adr_q.push_back(wb_o.adr);
                end
                wait_cnt = $urandom_range(0, 2);
            end else if (wb_o.cyc && wb_o.stb) begin
                if (wait_cnt == 0) begin
                    ack_next = 1'b1;
                    dat_next = mem_word(wb_o.adr);
                end else begin
                    wait_cnt--;
                end
            end
            #2;
            wb_i.ack = ack_next;
            wb_i.dat = dat_next;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the rows did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int seed_val;
        seed_val   = $urandom(SEED);
        rst_ni     = 1'b0;
        ar_valid_i = 1'b0;
        ar_i       = '0;
        r_ready_i  = 1'b1;
        errors     = 0;
        checks     = 0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        $display("Rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hdl/ccu_pkg.sv
hdl/stream_fork.sv
hdl/wb_line_master.sv
hdl/ccu_read_snoop.sv
hdl/ccu_top.sv
dv/ccu_asserts.sv
dv/ccu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := ccu_tb
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
